//--- files.f
mmu_pkg.sv
tlb_store.sv
walk_timer.sv
walk_fsm.sv
mmu_top.sv
mmu_properties.sv
tb_clock_gen.sv
mmu_tb.sv

//--- mmu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// translation unit widths, table base, walk timeout, state codes
// and the page-table entry union with its table and leaf views.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mmu_pkg;

    localparam int vpn_width       = 20;
    localparam int ppn_width       = 20;
    localparam int level_bits      = 10;  // index bits per table level.
    localparam int tlb_index_width = 4;
    localparam int tlb_entries     = 2 ** tlb_index_width;
    localparam int tag_width       = 20;  // the whole vpn is kept as tag.
    localparam int adr_width       = 32;
    localparam int data_width      = 32;
    localparam int pte_base_width  = 22;

    // word address of the first-level table. A table entry's next_base is
    // also a word address, and the second-level index is added to it.
    localparam logic [adr_width-1:0] root_base = 32'h0000_1000;

    localparam int walk_timeout = 16;  // cycles allowed per bus cycle.
    localparam int timer_width  = $clog2(walk_timeout);
    localparam logic [timer_width-1:0] timer_last = timer_width'(walk_timeout - 1);

    localparam int state_width = 3;
    localparam logic [state_width-1:0] st_idle    = 3'd0;
    localparam logic [state_width-1:0] st_lookup  = 3'd1;
    localparam logic [state_width-1:0] st_read1   = 3'd2;
    localparam logic [state_width-1:0] st_read2   = 3'd3;
    localparam logic [state_width-1:0] st_respond = 3'd4;

    // valid and is_leaf share bits 0 and 1 in both views.
    typedef union packed {
        struct packed {
            logic [pte_base_width-1:0] next_base;
            logic [7:0]                rsvd;
            logic                      is_leaf;
            logic                      valid;
        } tbl;
        struct packed {
            logic [ppn_width-1:0] ppn;
            logic [8:0]           rsvd;
            logic                 writable;
            logic                 is_leaf;
            logic                 valid;
        } pg;
    } pte_t;

endpackage

//--- mmu_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound assertions on the client handshake and Wishbone rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmu_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          req_valid,
    input logic                          req_ready,
    input logic                          resp_valid,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [mmu_pkg::adr_width-1:0] wb_adr
);

    logic accepted;  // set once the first request is taken after reset.

    always_ff @(posedge clk) begin
        if (rst) begin
            accepted <= 1'b0;
        end else if (req_valid && req_ready) begin
            accepted <= 1'b1;
        end
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb is high while wb_cyc is low");

    adr_held: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed before the bus cycle was acknowledged");

    no_ready_in_walk: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !req_ready)
        else $error("req_ready is high during a bus cycle");

    single_resp: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else $error("resp_valid stayed high for two cycles");

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !accepted |-> (!resp_valid && !wb_cyc))
        else $error("response or bus cycle before any request was accepted");

endmodule

bind mmu_top mmu_properties i_mmu_properties (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .wb_adr     (wb_adr)
);

//--- mmu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// translation unit testbench with Wishbone memory model, page-table
// builder, directed tests, compare tasks and watchdog.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmu_tb;

    localparam int clk_period_ns    = 8;
    localparam int num_tests        = 5;
    localparam int walk_cycles      = 2 * mmu_pkg::walk_timeout + 8;  // worst-case walk.
    localparam int watchdog_ns      = num_tests * walk_cycles * clk_period_ns * 4;
    localparam logic [31:0] l2_area = 32'h0001_0000;
    localparam int entry_mapped     = 0;
    localparam int entry_l1_invalid = 1;
    localparam int entry_l1_leaf    = 2;
    localparam int entry_l2_invalid = 3;

    logic                           clk;
    logic                           rst;
    logic                           flush;
    logic                           req_valid;
    logic                           req_ready;
    logic                           req_write;
    logic [mmu_pkg::vpn_width-1:0]  req_vpn;
    logic                           resp_valid;
    logic                           resp_fault;
    logic [mmu_pkg::ppn_width-1:0]  resp_ppn;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic [mmu_pkg::adr_width-1:0]  wb_adr;
    logic [mmu_pkg::data_width-1:0] wb_rdata = '0;
    logic                           wb_ack   = 1'b0;

    logic [mmu_pkg::data_width-1:0] mem [logic [mmu_pkg::adr_width-1:0]];
    logic [mmu_pkg::ppn_width-1:0]  ref_ppn [logic [mmu_pkg::vpn_width-1:0]];
    logic                           ref_writable [logic [mmu_pkg::vpn_width-1:0]];
    logic                           ref_fault [logic [mmu_pkg::vpn_width-1:0]];
    logic hold_ack     = 1'b0;
    logic cyc_prev     = 1'b0;
    int   ack_delay    = 0;
    int   wait_cnt     = 0;
    int   bus_cycles   = 0;
    int   error_count  = 0;
    int   test_errors  = 0;
    int   tests_failed = 0;
    int   last_latency = 0;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(4)) i_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    mmu_top i_mmu_top (.*);

    // memory answers ack_delay cycles after it first sees the strobe.
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack   = 1'b0;
            wait_cnt = 0;
        end else if (wb_cyc && wb_stb && !hold_ack) begin
            if (wait_cnt >= ack_delay) begin
                wb_rdata = mem.exists(wb_adr) ? mem[wb_adr] : '0;  // unwritten words are invalid.
                wb_ack   = 1'b1;
            end else begin
                wait_cnt++;
            end
        end else if (!wb_cyc) begin
            wait_cnt = 0;
        end
    end

    always @(negedge clk) begin
        if (wb_cyc && !cyc_prev) begin
            bus_cycles++;
        end
        cyc_prev = wb_cyc;
    end

    task automatic check_ppn(input string name, input logic [mmu_pkg::ppn_width-1:0] exp_v,
                             input logic [mmu_pkg::ppn_width-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED t=%0t %s expected=%b actual=%b", $time, name, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("CHECK FAILED t=%0t %s expected=%0d actual=%0d", $time, name, exp_v, act_v);
            error_count++;
        end
    endtask

    // writes both table levels for one page and records what a lookup should give.
    task automatic build_entry(input logic [mmu_pkg::vpn_width-1:0] vpn,
                               input logic [mmu_pkg::ppn_width-1:0] ppn,
                               input logic writable, input int kind);
        mmu_pkg::pte_t l1;
        mmu_pkg::pte_t l2;
        logic [31:0]   l1_adr;
        logic [31:0]   l2_base;
        l1_adr  = mmu_pkg::root_base + 32'(vpn[19:10]);
        l2_base = l2_area + {12'd0, vpn[19:10], 10'd0};  // one 1024-word table per slot.
        l1 = '0;
        l1.tbl.next_base = l2_base[21:0];
        l1.tbl.valid     = 1'b1;
        l2 = '0;
        l2.pg.ppn      = ppn;
        l2.pg.writable = writable;
        l2.pg.is_leaf  = 1'b1;
        l2.pg.valid    = 1'b1;
        if (kind == entry_l1_leaf) begin
            l1 = l2;
        end else if (kind == entry_l1_invalid) begin
            l1 = '0;
        end else if (kind == entry_l2_invalid) begin
            l2 = '0;
        end
        mem[l1_adr]                  = l1;
        mem[l2_base + 32'(vpn[9:0])] = l2;
        ref_ppn[vpn]      = ppn;
        ref_writable[vpn] = writable;
        ref_fault[vpn]    = (kind != entry_mapped);
    endtask

    task automatic request_translation(input logic [mmu_pkg::vpn_width-1:0] vpn,
                                       input logic write, output logic fault,
                                       output logic [mmu_pkg::ppn_width-1:0] ppn,
                                       output int cycles);
        int start_count;
        int waited;
        fault  = 1'bx;
        ppn    = 'x;
        cycles = -1;
        waited = 0;
        while (!req_ready && waited < walk_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!req_ready) begin
            $display("ERROR t=%0t the DUT never raised req_ready for vpn %h", $time, vpn);
            error_count++;
            return;
        end
        start_count = bus_cycles;
        req_valid = 1'b1;
        req_write = write;
        req_vpn   = vpn;
        @(posedge clk);
        #1;
        req_valid    = 1'b0;
        last_latency = 0;  // cycles counted from the accepting edge.
        while (!resp_valid && last_latency < 2 * walk_cycles) begin
            @(posedge clk);
            #1;
            last_latency++;
        end
        if (!resp_valid) begin
            $display("ERROR t=%0t no response came for vpn %h", $time, vpn);
            error_count++;
            return;
        end
        fault  = resp_fault;
        ppn    = resp_ppn;
        cycles = bus_cycles - start_count;
    endtask

    task automatic run_access(input string label, input logic [mmu_pkg::vpn_width-1:0] vpn,
                              input logic write, input int exp_cycles);
        logic                          fault;
        logic [mmu_pkg::ppn_width-1:0] ppn;
        int                            cycles;
        logic                          exp_fault;
        request_translation(vpn, write, fault, ppn, cycles);
        exp_fault = ref_fault[vpn] | (write & ~ref_writable[vpn]);
        check_flag({label, ": resp_fault"}, exp_fault, fault);
        if (!exp_fault) begin
            check_ppn({label, ": resp_ppn"}, ref_ppn[vpn], ppn);
        end
        check_count({label, ": bus cycles"}, exp_cycles, cycles);
    endtask

    task automatic test_walk_then_hit();
        build_entry(20'h12345, 20'hABCDE, 1'b1, entry_mapped);
        run_access("first access", 20'h12345, 1'b0, 2);
        run_access("repeat access", 20'h12345, 1'b0, 0);
        check_count("repeat access: resp_valid latency", 2, last_latency);
    endtask

    task automatic test_permission();
        build_entry(20'h23456, 20'h11111, 1'b0, entry_mapped);
        build_entry(20'h34567, 20'h22222, 1'b1, entry_mapped);
        run_access("read of read-only page", 20'h23456, 1'b0, 2);
        run_access("write to read-only page", 20'h23456, 1'b1, 0);
        run_access("write to writable page", 20'h34567, 1'b1, 2);
    endtask

    task automatic test_bad_entries();
        build_entry(20'h45678, 20'h00000, 1'b0, entry_l1_invalid);
        build_entry(20'h56789, 20'h44444, 1'b0, entry_l1_leaf);
        build_entry(20'h6789A, 20'h00000, 1'b0, entry_l2_invalid);
        run_access("invalid first level", 20'h45678, 1'b0, 1);
        run_access("invalid first level again", 20'h45678, 1'b0, 1);
        run_access("leaf at first level", 20'h56789, 1'b0, 1);
        run_access("leaf at first level again", 20'h56789, 1'b0, 1);
        run_access("invalid second level", 20'h6789A, 1'b0, 2);
        run_access("invalid second level again", 20'h6789A, 1'b0, 2);
    endtask

    task automatic test_timeout();
        logic                          fault;
        logic [mmu_pkg::ppn_width-1:0] ppn;
        int                            cycles;
        build_entry(20'h789AB, 20'h0F0F0, 1'b1, entry_mapped);
        hold_ack = 1'b1;
        request_translation(20'h789AB, 1'b0, fault, ppn, cycles);
        check_flag("withheld ack: resp_fault", 1'b1, fault);
        check_count("withheld ack: bus cycles", 1, cycles);
        check_flag("withheld ack: wb_cyc", 1'b0, wb_cyc);
        hold_ack = 1'b0;
        run_access("access after timeout", 20'h789AB, 1'b0, 2);
    endtask

    task automatic test_flush_alias();
        logic [mmu_pkg::vpn_width-1:0] alias_vpn [3];
        logic [mmu_pkg::vpn_width-1:0] vpn;
        build_entry(20'h0ABC3, 20'h33333, 1'b1, entry_mapped);
        run_access("before flush", 20'h0ABC3, 1'b0, 2);
        run_access("cached before flush", 20'h0ABC3, 1'b0, 0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        run_access("after flush", 20'h0ABC3, 1'b0, 2);
        // all aliases land on store index 9 and sit above the fixed tables.
        for (int i = 0; i < 3; i++) begin
            do begin
                vpn = {2'b11, 14'($urandom), 4'h9};
            end while (ref_ppn.exists(vpn));
            alias_vpn[i] = vpn;
            build_entry(vpn, 20'($urandom), 1'($urandom), entry_mapped);
            run_access("alias walk", vpn, 1'b0, 2);
        end
        run_access("return to evicted alias", alias_vpn[0], 1'b0, 2);
        run_access("alias cached again", alias_vpn[0], 1'b0, 0);
    endtask

    task automatic start_test();
        test_errors = error_count;
        ack_delay   = $urandom_range(3, 0);
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            $display("test %s: ok (ack delay %0d)", name, ack_delay);
        end else begin
            $display("test %s: %0d errors", name, error_count - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        int seed_ret;
        seed_ret  = $urandom(29936);
        flush     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_vpn   = '0;
        @(negedge rst);
        start_test();
        test_walk_then_hit();
        finish_test("walk then hit");
        start_test();
        test_permission();
        finish_test("permission");
        start_test();
        test_bad_entries();
        finish_test("bad entries");
        start_test();
        test_timeout();
        finish_test("timeout");
        start_test();
        test_flush_alias();
        finish_test("flush and aliasing");
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 num_tests, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("ERROR the run did not finish within %0d ns", watchdog_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- mmu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// translation unit top: store, bus timer and walk FSM.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [mmu_pkg::vpn_width-1:0]  req_vpn,
    output logic                           resp_valid,
    output logic                           resp_fault,
    output logic [mmu_pkg::ppn_width-1:0]  resp_ppn,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [mmu_pkg::adr_width-1:0]  wb_adr,
    input  logic [mmu_pkg::data_width-1:0] wb_rdata,
    input  logic                           wb_ack
);

    logic                          lookup_valid;
    logic [mmu_pkg::vpn_width-1:0] lookup_vpn;
    logic                          hit_valid;
    logic                          hit;
    logic [mmu_pkg::ppn_width-1:0] hit_ppn;
    logic                          hit_writable;
    logic                          update_valid;
    logic [mmu_pkg::vpn_width-1:0] update_vpn;
    logic [mmu_pkg::ppn_width-1:0] update_ppn;
    logic                          update_writable;
    logic                          timer_start;
    logic                          timer_stop;
    logic                          expired;

    tlb_store i_tlb_store (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .lookup_valid    (lookup_valid),
        .lookup_vpn      (lookup_vpn),
        .hit_valid       (hit_valid),
        .hit             (hit),
        .hit_ppn         (hit_ppn),
        .hit_writable    (hit_writable),
        .update_valid    (update_valid),
        .update_vpn      (update_vpn),
        .update_ppn      (update_ppn),
        .update_writable (update_writable)
    );

    walk_timer i_walk_timer (
        .clk         (clk),
        .rst         (rst),
        .timer_start (timer_start),
        .timer_stop  (timer_stop),
        .expired     (expired)
    );

    walk_fsm i_walk_fsm (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_write       (req_write),
        .req_vpn         (req_vpn),
        .resp_valid      (resp_valid),
        .resp_fault      (resp_fault),
        .resp_ppn        (resp_ppn),
        .lookup_valid    (lookup_valid),
        .lookup_vpn      (lookup_vpn),
        .hit_valid       (hit_valid),
        .hit             (hit),
        .hit_ppn         (hit_ppn),
        .hit_writable    (hit_writable),
        .update_valid    (update_valid),
        .update_vpn      (update_vpn),
        .update_ppn      (update_ppn),
        .update_writable (update_writable),
        .timer_start     (timer_start),
        .timer_stop      (timer_stop),
        .expired         (expired),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_adr          (wb_adr),
        .wb_rdata        (wb_rdata),
        .wb_ack          (wb_ack)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the translation unit testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb -f files.f -o sim_mmu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_mmu > sim.log 2>&1
cat sim.log

grep -q "^Verification passed$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and synchronous reset generator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;  // released just after an edge, like all other stimulus.
    end

endmodule

//--- tlb_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped translation store with registered lookup and flush.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tlb_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          lookup_valid,
    input  logic [mmu_pkg::vpn_width-1:0] lookup_vpn,
    output logic                          hit_valid,
    output logic                          hit,
    output logic [mmu_pkg::ppn_width-1:0] hit_ppn,
    output logic                          hit_writable,
    input  logic                          update_valid,
    input  logic [mmu_pkg::vpn_width-1:0] update_vpn,
    input  logic [mmu_pkg::ppn_width-1:0] update_ppn,
    input  logic                          update_writable
);

    logic [mmu_pkg::tlb_entries-1:0]     valid_mem;
    logic [mmu_pkg::tlb_entries-1:0]     writable_mem;
    logic [mmu_pkg::tag_width-1:0]       tag_mem [mmu_pkg::tlb_entries];
    logic [mmu_pkg::ppn_width-1:0]       ppn_mem [mmu_pkg::tlb_entries];
    logic [mmu_pkg::tlb_index_width-1:0] lookup_idx;
    logic [mmu_pkg::tlb_index_width-1:0] update_idx;
    logic                                tag_match;

    assign lookup_idx = lookup_vpn[mmu_pkg::tlb_index_width-1:0];
    assign update_idx = update_vpn[mmu_pkg::tlb_index_width-1:0];
    assign tag_match  = valid_mem[lookup_idx] & (tag_mem[lookup_idx] == lookup_vpn);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
            hit_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            hit_valid <= lookup_valid;
            hit       <= lookup_valid & tag_match & ~flush;  // flush wins over a lookup.
            if (flush) begin
                valid_mem <= '0;
            end
            // an install from a walk in flight still lands after a flush.
            if (update_valid) begin
                valid_mem[update_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        hit_ppn      <= ppn_mem[lookup_idx];
        hit_writable <= writable_mem[lookup_idx];
        if (update_valid) begin  // an alias at the same index is simply replaced.
            tag_mem[update_idx]      <= update_vpn;
            ppn_mem[update_idx]      <= update_ppn;
            writable_mem[update_idx] <= update_writable;
        end
    end

endmodule

//--- walk_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request FSM with lookup, permission check and two-level walk
// over a read-only Wishbone classic master port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module walk_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [mmu_pkg::vpn_width-1:0]  req_vpn,
    output logic                           resp_valid,
    output logic                           resp_fault,
    output logic [mmu_pkg::ppn_width-1:0]  resp_ppn,
    output logic                           lookup_valid,
    output logic [mmu_pkg::vpn_width-1:0]  lookup_vpn,
    input  logic                           hit_valid,
    input  logic                           hit,
    input  logic [mmu_pkg::ppn_width-1:0]  hit_ppn,
    input  logic                           hit_writable,
    output logic                           update_valid,
    output logic [mmu_pkg::vpn_width-1:0]  update_vpn,
    output logic [mmu_pkg::ppn_width-1:0]  update_ppn,
    output logic                           update_writable,
    output logic                           timer_start,
    output logic                           timer_stop,
    input  logic                           expired,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [mmu_pkg::adr_width-1:0]  wb_adr,
    input  logic [mmu_pkg::data_width-1:0] wb_rdata,
    input  logic                           wb_ack
);

    logic [mmu_pkg::state_width-1:0] state;
    logic [mmu_pkg::vpn_width-1:0]   vpn_q;
    logic                            write_q;
    mmu_pkg::pte_t                   pte;
    logic [mmu_pkg::adr_width-1:0]   l1_adr;
    logic [mmu_pkg::adr_width-1:0]   l2_adr;
    logic                            in_read;

    assign pte     = wb_rdata;
    assign in_read = (state == mmu_pkg::st_read1) || (state == mmu_pkg::st_read2);

    assign l1_adr = mmu_pkg::root_base
                  + {{(mmu_pkg::adr_width - mmu_pkg::level_bits){1'b0}},
                     vpn_q[mmu_pkg::vpn_width-1 -: mmu_pkg::level_bits]};
    assign l2_adr = {{(mmu_pkg::adr_width - mmu_pkg::pte_base_width){1'b0}}, pte.tbl.next_base}
                  + {{(mmu_pkg::adr_width - mmu_pkg::level_bits){1'b0}},
                     vpn_q[mmu_pkg::level_bits-1:0]};

    assign req_ready   = (state == mmu_pkg::st_idle);
    assign resp_valid  = (state == mmu_pkg::st_respond);  // respond lasts one cycle.
    assign lookup_vpn  = vpn_q;
    assign update_vpn  = vpn_q;
    assign update_ppn  = resp_ppn;
    assign timer_start = in_read & ~wb_cyc;  // same cycle that cyc is raised.
    assign timer_stop  = wb_cyc & wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mmu_pkg::st_idle;
            lookup_valid <= 1'b0;
            update_valid <= 1'b0;
            wb_cyc       <= 1'b0;
            wb_stb       <= 1'b0;
        end else begin
            lookup_valid <= 1'b0;
            update_valid <= 1'b0;
            case (state)
                mmu_pkg::st_idle: begin
                    if (req_valid) begin
                        vpn_q        <= req_vpn;
                        write_q      <= req_write;
                        lookup_valid <= 1'b1;
                        state        <= mmu_pkg::st_lookup;
                    end
                end
                mmu_pkg::st_lookup: begin
                    // the store answers one cycle after the lookup pulse.
                    if (hit_valid && hit) begin
                        resp_ppn   <= hit_ppn;
                        resp_fault <= write_q & ~hit_writable;
                        state      <= mmu_pkg::st_respond;
                    end else if (hit_valid) begin
                        wb_adr <= l1_adr;
                        state  <= mmu_pkg::st_read1;
                    end
                end
                mmu_pkg::st_read1, mmu_pkg::st_read2: begin
                    if (!wb_cyc) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end else if (wb_ack || expired) begin
                        // every exit is a fault unless the entry checks out.
                        wb_cyc     <= 1'b0;
                        wb_stb     <= 1'b0;
                        resp_fault <= 1'b1;
                        resp_ppn   <= '0;
                        state      <= mmu_pkg::st_respond;
                        if (wb_ack && state == mmu_pkg::st_read1
                            && pte.tbl.valid && !pte.tbl.is_leaf) begin
                            wb_adr <= l2_adr;
                            state  <= mmu_pkg::st_read2;
                        end
                        if (wb_ack && state == mmu_pkg::st_read2
                            && pte.pg.valid && pte.pg.is_leaf) begin
                            resp_ppn        <= pte.pg.ppn;
                            resp_fault      <= write_q & ~pte.pg.writable;
                            update_valid    <= 1'b1;  // installed even on a write fault.
                            update_writable <= pte.pg.writable;
                        end
                    end
                end
                mmu_pkg::st_respond: begin
                    state <= mmu_pkg::st_idle;
                end
                default: begin
                    state <= mmu_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

//--- walk_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus cycle watchdog counter with a one-cycle expiry pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module walk_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    input  logic timer_stop,
    output logic expired
);

    logic                            armed;
    logic [mmu_pkg::timer_width-1:0] count;

    // start comes with the rising edge of cyc, so expired is raised after
    // walk_timeout cycles of an open bus cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            armed   <= 1'b0;
            count   <= '0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (timer_start) begin  // a restart beats a stop in the same cycle.
                armed <= 1'b1;
                count <= '0;
            end else if (timer_stop) begin
                armed <= 1'b0;
                count <= '0;
            end else if (armed) begin
                if (count == mmu_pkg::timer_last) begin
                    expired <= 1'b1;
                    armed   <= 1'b0;  // count stays at its limit.
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule
